//--- files.f
source/rbus_pkg.sv
source/crcgc_regs_pkg.sv
source/rbus_ring_node.sv
source/crcgc_regs.sv
source/hb_snapshot.sv
source/crcgc_regfile.sv
sim/crcgc_regfile_tb.sv

//--- sim/crcgc_regfile_tb.sv
// Directed testbench for the CRC generator/checker register file with
// ring tasks, LFSR stimulus and a watchdog.
`timescale 1ns/10ps
`default_nettype none

module crcgc_regfile_tb;

  import rbus_pkg::*;
  import crcgc_regs_pkg::*;

  localparam logic [15:0] WIN_START  = 16'h0100;
  localparam logic [15:0] WIN_END    = 16'h011f;
  // ring transactions issued by all tests together.
  localparam int          N_RING_TXN = 106;

  logic        clk = 1'b0;
  logic        reset;
  rbus_ring_t  ring_in;
  rbus_ring_t  ring_out;
  logic [15:0] cfg_start;
  logic [15:0] cfg_end;
  hb_array_t   cts_hb;
  logic [31:0] tlv0;
  logic [31:0] tlv1;
  logic        gen_en;
  logic        chk_en;
  logic [31:0] lfsr = 32'hf3f757b7;
  logic [31:0] spare_exp;
  logic [31:0] tlv0_exp;
  logic [31:0] tlv1_exp;
  logic [31:0] ctrl_exp;
  int          err_count = 0;

  crcgc_regfile #(
    .N_LOCL_ADDR_BITS (8),
    .REVID            (8'h21)
  ) crcgc_regfile_i (
    .clk                  (clk),
    .i_reset              (reset),
    .i_rbus_ring          (ring_in),
    .o_rbus_ring          (ring_out),
    .i_cfg_start_addr     (cfg_start),
    .i_cfg_end_addr       (cfg_end),
    .i_cts_hb             (cts_hb),
    .o_tlv_parse_action_0 (tlv0),
    .o_tlv_parse_action_1 (tlv1),
    .o_crc_gen_en         (gen_en),
    .o_crc_chk_en         (chk_en)
  );

  always #2 clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [15:0] reg_addr(input int word);
    return cfg_start + 16'(word);
  endfunction

  task automatic stop_run();
    err_count++;
    $display("Test failures found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] exp_val,
                             input logic [127:0] act_val);
    if (exp_val !== act_val) begin
      $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp_val,
               act_val);
      stop_run();
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic ring_request(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                              input logic exp_err, output logic [31:0] rdata);
    rbus_ring_t word;
    word         = '0;
    word.addr    = addr;
    word.wr_strb = wr;
    word.rd_strb = !wr;
    word.wr_data = wdata;
    ring_in      = word;
    next_cycle();
    ring_in = '0;
    // the two slots behind the request stay empty while the registers answer.
    repeat (2) begin
      next_cycle();
      if (ring_out.ack || ring_out.err_ack) begin
        report_error($sformatf("response to address %h came too early", addr));
      end
    end
    next_cycle();
    if (!(ring_out.ack || ring_out.err_ack)) begin
      report_error($sformatf("no response to the request at address %h", addr));
    end
    check_value("o_rbus_ring.ack", !exp_err, ring_out.ack);
    check_value("o_rbus_ring.err_ack", exp_err, ring_out.err_ack);
    check_value("o_rbus_ring.addr", addr, ring_out.addr);
    rdata = ring_out.rd_data;
    next_cycle();
    if (ring_out.ack || ring_out.err_ack) begin
      report_error($sformatf("second response to the request at address %h", addr));
    end
  endtask

  task automatic ring_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic exp_err);
    logic [31:0] unused;
    ring_request(1'b1, addr, data, exp_err, unused);
  endtask

  task automatic ring_read(input logic [15:0] addr, input logic [31:0] exp_data,
                           input logic exp_err, input string name);
    logic [31:0] rdata;
    ring_request(1'b0, addr, '0, exp_err, rdata);
    check_value(name, exp_data, rdata);
  endtask

  task automatic fill_history();
    for (int n = 0; n < N_HB_ENTRIES; n++) begin
      for (int p = 0; p < 3; p++) begin
        cts_hb[n][32*p +: 32] = rand_word();
      end
    end
  endtask

  // entry n, part p is read at REG_HB_BASE + 3n + p.
  task automatic read_history(input hb_array_t exp_hb);
    for (int i = 0; i < 3 * N_HB_ENTRIES; i++) begin
      ring_read(reg_addr(REG_HB_BASE + i), exp_hb[i/3][32*(i%3) +: 32], 1'b0,
                $sformatf("history word %0d", i));
    end
  endtask

  task automatic reset_and_identity();
    check_value("o_rbus_ring", '0, ring_out);
    check_value("o_crc_gen_en", 1'b0, gen_en);
    check_value("o_crc_chk_en", 1'b0, chk_en);
    ring_read(reg_addr(REG_REVID), 32'h21, 1'b0, "REVID");
    ring_read(reg_addr(REG_SPARE), '0, 1'b0, "SPARE");
    ring_read(reg_addr(REG_TLV_ACTION_0), '0, 1'b0, "TLV_ACTION_0");
    ring_read(reg_addr(REG_TLV_ACTION_1), '0, 1'b0, "TLV_ACTION_1");
    ring_read(reg_addr(REG_CTRL), '0, 1'b0, "CTRL");
  endtask

  task automatic rw_registers();
    logic [31:0] ctrl_wr;
    spare_exp = rand_word();
    tlv0_exp  = rand_word();
    tlv1_exp  = rand_word();
    ctrl_wr   = rand_word();
    ctrl_exp  = {29'b0, ctrl_wr[2:0]};
    ring_write(reg_addr(REG_SPARE), spare_exp, 1'b0);
    ring_write(reg_addr(REG_TLV_ACTION_0), tlv0_exp, 1'b0);
    ring_write(reg_addr(REG_TLV_ACTION_1), tlv1_exp, 1'b0);
    ring_write(reg_addr(REG_CTRL), ctrl_wr, 1'b0);
    ring_read(reg_addr(REG_SPARE), spare_exp, 1'b0, "SPARE");
    ring_read(reg_addr(REG_TLV_ACTION_0), tlv0_exp, 1'b0, "TLV_ACTION_0");
    ring_read(reg_addr(REG_TLV_ACTION_1), tlv1_exp, 1'b0, "TLV_ACTION_1");
    ring_read(reg_addr(REG_CTRL), ctrl_exp, 1'b0, "CTRL");
    check_value("o_tlv_parse_action_0", tlv0_exp, tlv0);
    check_value("o_tlv_parse_action_1", tlv1_exp, tlv1);
    check_value("o_crc_gen_en", ctrl_exp[0], gen_en);
    check_value("o_crc_chk_en", ctrl_exp[1], chk_en);
  endtask

  task automatic history_freeze();
    hb_array_t old_hb;
    ctrl_exp = '0;
    ring_write(reg_addr(REG_CTRL), ctrl_exp, 1'b0);
    fill_history();
    repeat (2) next_cycle();
    read_history(cts_hb);
    old_hb   = cts_hb;
    ctrl_exp = 32'h4;
    ring_write(reg_addr(REG_CTRL), ctrl_exp, 1'b0);
    fill_history();
    repeat (2) next_cycle();
    read_history(old_hb);
    ctrl_exp = '0;
    ring_write(reg_addr(REG_CTRL), ctrl_exp, 1'b0);
    repeat (2) next_cycle();
    read_history(cts_hb);
  endtask

  task automatic error_responses();
    // a wider window brings local address 40 inside it.
    cfg_end = 16'h01ff;
    ring_write(reg_addr(REG_REVID), rand_word(), 1'b1);
    ring_write(reg_addr(REG_HB_BASE), rand_word(), 1'b1);
    ring_write(reg_addr(6), rand_word(), 1'b1);
    ring_read(reg_addr(40), '0, 1'b1, "unmapped read data");
    cfg_end = WIN_END;
    ring_read(reg_addr(REG_REVID), 32'h21, 1'b0, "REVID");
    ring_read(reg_addr(REG_HB_BASE), cts_hb[0][31:0], 1'b0, "history word 0");
    ring_read(reg_addr(REG_SPARE), spare_exp, 1'b0, "SPARE");
    ring_read(reg_addr(REG_CTRL), ctrl_exp, 1'b0, "CTRL");
  endtask

  task automatic foreign_forwarding();
    rbus_ring_t words [4];
    for (int i = 0; i < 4; i++) begin
      words[i] = '0;
    end
    words[0].addr    = WIN_START - 16'd1;
    words[0].wr_strb = 1'b1;
    words[0].wr_data = rand_word();
    words[1].addr    = WIN_END + 16'd1;
    words[1].rd_strb = 1'b1;
    words[2].addr    = WIN_START + 16'd5;
    words[2].ack     = 1'b1;
    words[2].rd_data = rand_word();
    words[3].addr    = 16'h0010;
    words[3].err_ack = 1'b1;
    words[3].rd_data = rand_word();
    // each word leaves the node one edge after it was sampled.
    for (int i = 0; i < 5; i++) begin
      if (i < 4) begin
        ring_in = words[i];
      end else begin
        ring_in = '0;
      end
      next_cycle();
      if (i > 0) begin
        check_value($sformatf("forwarded o_rbus_ring word %0d", i - 1), words[i-1], ring_out);
      end
    end
    ring_read(reg_addr(REG_SPARE), spare_exp, 1'b0, "SPARE");
    ring_read(reg_addr(REG_TLV_ACTION_0), tlv0_exp, 1'b0, "TLV_ACTION_0");
  endtask

  task automatic window_move();
    rbus_ring_t old_word;
    cfg_start = 16'h0200;
    cfg_end   = 16'h021f;
    ring_read(16'h0201, spare_exp, 1'b0, "SPARE in moved window");
    spare_exp = rand_word();
    ring_write(16'h0201, spare_exp, 1'b0);
    ring_read(16'h0201, spare_exp, 1'b0, "SPARE in moved window");
    old_word         = '0;
    old_word.addr    = 16'h0101;
    old_word.rd_strb = 1'b1;
    ring_in          = old_word;
    next_cycle();
    ring_in = '0;
    next_cycle();
    check_value("o_rbus_ring at old address", old_word, ring_out);
    next_cycle();
    check_value("o_rbus_ring after forwarding", '0, ring_out);
  endtask

  initial begin
    reset     = 1'b1;
    ring_in   = '0;
    cfg_start = WIN_START;
    cfg_end   = WIN_END;
    cts_hb    = '0;
    repeat (10) @(posedge clk);
    #0.5;
    reset = 1'b0;
    reset_and_identity();
    rw_registers();
    history_freeze();
    error_responses();
    foreign_forwarding();
    window_move();
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // five clocks per ring transaction, so 200 ns each leaves a wide margin.
  initial begin
    #(N_RING_TXN * 200 + 100);
    $display("Watchdog expired before all tests finished");
    $display("Test failures found");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- source/crcgc_regfile.sv
// CRC generator/checker register file: ring node, register block and
// history snapshot.
`timescale 1ns/10ps
`default_nettype none

module crcgc_regfile #(
  parameter int         N_LOCL_ADDR_BITS = 8,
  parameter logic [7:0] REVID            = 8'h21
) (
  input  wire logic                                clk,
  input  wire logic                                i_reset,
  input  wire rbus_pkg::rbus_ring_t                i_rbus_ring,
  output rbus_pkg::rbus_ring_t                     o_rbus_ring,
  input  wire logic [rbus_pkg::RBUS_ADDR_BITS-1:0] i_cfg_start_addr,
  input  wire logic [rbus_pkg::RBUS_ADDR_BITS-1:0] i_cfg_end_addr,
  input  wire crcgc_regs_pkg::hb_array_t           i_cts_hb,
  output logic [rbus_pkg::RBUS_DATA_BITS-1:0]      o_tlv_parse_action_0,
  output logic [rbus_pkg::RBUS_DATA_BITS-1:0]      o_tlv_parse_action_1,
  output logic                                     o_crc_gen_en,
  output logic                                     o_crc_chk_en
);

  import rbus_pkg::*;
  import crcgc_regs_pkg::*;

  logic [N_LOCL_ADDR_BITS-1:0] locl_addr;
  logic                        locl_wr_strb;
  logic                        locl_rd_strb;
  logic [RBUS_DATA_BITS-1:0]   locl_wr_data;
  logic [RBUS_DATA_BITS-1:0]   locl_rd_data;
  logic                        locl_ack;
  logic                        locl_err_ack;
  crcgc_ctrl_t                 ctrl;
  hb_array_t                   hb_snap;

  assign o_crc_gen_en = ctrl.crc_gen_en;
  assign o_crc_chk_en = ctrl.crc_chk_en;

  rbus_ring_node #(
    .N_LOCL_ADDR_BITS (N_LOCL_ADDR_BITS)
  ) u_rbus_ring_node (
    .clk              (clk),
    .i_reset          (i_reset),
    .i_rbus_ring      (i_rbus_ring),
    .i_cfg_start_addr (i_cfg_start_addr),
    .i_cfg_end_addr   (i_cfg_end_addr),
    .i_locl_rd_data   (locl_rd_data),
    .i_locl_ack       (locl_ack),
    .i_locl_err_ack   (locl_err_ack),
    .o_rbus_ring      (o_rbus_ring),
    .o_locl_addr      (locl_addr),
    .o_locl_wr_strb   (locl_wr_strb),
    .o_locl_wr_data   (locl_wr_data),
    .o_locl_rd_strb   (locl_rd_strb)
  );

  crcgc_regs #(
    .N_LOCL_ADDR_BITS (N_LOCL_ADDR_BITS),
    .REVID            (REVID)
  ) u_crcgc_regs (
    .clk                  (clk),
    .i_reset              (i_reset),
    .i_addr               (locl_addr),
    .i_wr_strb            (locl_wr_strb),
    .i_wr_data            (locl_wr_data),
    .i_rd_strb            (locl_rd_strb),
    .i_hb                 (hb_snap),
    .o_rd_data            (locl_rd_data),
    .o_ack                (locl_ack),
    .o_err_ack            (locl_err_ack),
    .o_tlv_parse_action_0 (o_tlv_parse_action_0),
    .o_tlv_parse_action_1 (o_tlv_parse_action_1),
    .o_ctrl               (ctrl)
  );

  hb_snapshot u_hb_snapshot (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_cts_hb (i_cts_hb),
    .i_freeze (ctrl.hb_freeze),
    .o_hb     (hb_snap)
  );

endmodule

`default_nettype wire

//--- source/hb_snapshot.sv
// Freezable copy of the history buffer entries shown through the register
// window.
`timescale 1ns/10ps
`default_nettype none

module hb_snapshot (
  input  wire logic                      clk,
  input  wire logic                      i_reset,
  input  wire crcgc_regs_pkg::hb_array_t i_cts_hb,
  input  wire logic                      i_freeze,
  output crcgc_regs_pkg::hb_array_t      o_hb
);

  // The live buffer keeps moving. While frozen, software can read all
  // three parts of an entry and get one consistent value.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_hb <= '0;
    end else if (!i_freeze) begin
      o_hb <= i_cts_hb;
    end
  end

endmodule

`default_nettype wire

//--- source/crcgc_regs.sv
// CRC generator/checker register block: RW and RO registers, history
// buffer read window, read mux and ack/err_ack generation.
`timescale 1ns/10ps
`default_nettype none

module crcgc_regs #(
  parameter int         N_LOCL_ADDR_BITS = 8,
  parameter logic [7:0] REVID            = 8'h21
) (
  input  wire logic                                clk,
  input  wire logic                                i_reset,
  input  wire logic [N_LOCL_ADDR_BITS-1:0]         i_addr,
  input  wire logic                                i_wr_strb,
  input  wire logic [rbus_pkg::RBUS_DATA_BITS-1:0] i_wr_data,
  input  wire logic                                i_rd_strb,
  input  wire crcgc_regs_pkg::hb_array_t           i_hb,
  output logic [rbus_pkg::RBUS_DATA_BITS-1:0]      o_rd_data,
  output logic                                     o_ack,
  output logic                                     o_err_ack,
  output logic [rbus_pkg::RBUS_DATA_BITS-1:0]      o_tlv_parse_action_0,
  output logic [rbus_pkg::RBUS_DATA_BITS-1:0]      o_tlv_parse_action_1,
  output crcgc_regs_pkg::crcgc_ctrl_t              o_ctrl
);

  import rbus_pkg::*;
  import crcgc_regs_pkg::*;

  logic [RBUS_DATA_BITS-1:0]               spare_q;
  logic [N_HB_ENTRIES*HB_ENTRY_BITS-1:0]   hb_flat;
  logic [N_LOCL_ADDR_BITS-1:0]             hb_idx;
  logic                                    is_hb;
  logic [RBUS_DATA_BITS-1:0]               rd_val;
  logic                                    rd_ok;
  logic                                    wr_ok;
  crcgc_ctrl_t                             ctrl_wr;

  // Entry n part p lands on word 3n+p of the flattened buffer.
  assign hb_flat = i_hb;
  assign is_hb   = (i_addr >= REG_HB_BASE) && (i_addr < REG_HB_BASE + N_HB_WORDS);
  assign hb_idx  = N_LOCL_ADDR_BITS'(i_addr - REG_HB_BASE);

  always_comb begin
    rd_val = '0;
    rd_ok  = 1'b1;
    if (is_hb) begin
      rd_val = hb_flat[RBUS_DATA_BITS*hb_idx +: RBUS_DATA_BITS];
    end else begin
      case (i_addr)
        REG_REVID:        rd_val = {{(RBUS_DATA_BITS-8){1'b0}}, REVID};
        REG_SPARE:        rd_val = spare_q;
        REG_TLV_ACTION_0: rd_val = o_tlv_parse_action_0;
        REG_TLV_ACTION_1: rd_val = o_tlv_parse_action_1;
        REG_CTRL:         rd_val = o_ctrl;
        default:          rd_ok  = 1'b0;
      endcase
    end
  end

  // only the writable registers accept a write, everything else errors.
  always_comb begin
    case (i_addr)
      REG_SPARE, REG_TLV_ACTION_0, REG_TLV_ACTION_1, REG_CTRL: wr_ok = 1'b1;
      default:                                                wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    ctrl_wr          = i_wr_data;
    ctrl_wr.reserved = '0;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      spare_q              <= '0;
      o_tlv_parse_action_0 <= '0;
      o_tlv_parse_action_1 <= '0;
      o_ctrl               <= '0;
      o_ack                <= 1'b0;
      o_err_ack            <= 1'b0;
    end else begin
      o_ack     <= (i_wr_strb && wr_ok) || (i_rd_strb && rd_ok);
      o_err_ack <= (i_wr_strb && !wr_ok) || (i_rd_strb && !rd_ok);
      if (i_wr_strb && wr_ok) begin
        case (i_addr)
          REG_SPARE:        spare_q              <= i_wr_data;
          REG_TLV_ACTION_0: o_tlv_parse_action_0 <= i_wr_data;
          REG_TLV_ACTION_1: o_tlv_parse_action_1 <= i_wr_data;
          default:          o_ctrl               <= ctrl_wr;
        endcase
      end
    end
  end

  // Write responses carry zero data.
  always_ff @(posedge clk) begin
    if (i_wr_strb || i_rd_strb) begin
      o_rd_data <= i_rd_strb ? rd_val : '0;
    end
  end

  // Only one kind of response is given for a strobe.
  a_ack_exclusive: assert property (@(posedge clk) disable iff (i_reset)
    !(o_ack && o_err_ack));

endmodule

`default_nettype wire

//--- source/rbus_ring_node.sv
// Ring node: window decode, forwarding of foreign words, local register
// strobes and insertion of the local response into the ring.
`timescale 1ns/10ps
`default_nettype none

module rbus_ring_node #(
  parameter int N_LOCL_ADDR_BITS = 8
) (
  input  wire logic                                  clk,
  input  wire logic                                  i_reset,
  input  wire rbus_pkg::rbus_ring_t                  i_rbus_ring,
  input  wire logic [rbus_pkg::RBUS_ADDR_BITS-1:0]   i_cfg_start_addr,
  input  wire logic [rbus_pkg::RBUS_ADDR_BITS-1:0]   i_cfg_end_addr,
  input  wire logic [rbus_pkg::RBUS_DATA_BITS-1:0]   i_locl_rd_data,
  input  wire logic                                  i_locl_ack,
  input  wire logic                                  i_locl_err_ack,
  output rbus_pkg::rbus_ring_t                       o_rbus_ring,
  output logic [N_LOCL_ADDR_BITS-1:0]                o_locl_addr,
  output logic                                       o_locl_wr_strb,
  output logic [rbus_pkg::RBUS_DATA_BITS-1:0]        o_locl_wr_data,
  output logic                                       o_locl_rd_strb
);

  import rbus_pkg::*;

  rbus_ring_t                ring_q;
  rbus_ring_t                rsp_word;
  logic                      in_win;
  logic                      hit;
  logic                      rsp_valid;
  logic                      pend_q;
  logic [RBUS_ADDR_BITS-1:0] pend_addr_q;
  logic [RBUS_ADDR_BITS-1:0] rel_addr;

  // the incoming word is registered first, decode works on the copy.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      ring_q <= '0;
    end else begin
      ring_q <= i_rbus_ring;
    end
  end

  // Response words are never claimed, only strobes inside the window.
  assign in_win    = (ring_q.addr >= i_cfg_start_addr) && (ring_q.addr <= i_cfg_end_addr);
  assign hit       = (ring_q.wr_strb || ring_q.rd_strb) && in_win;
  assign rel_addr  = ring_q.addr - i_cfg_start_addr;
  assign rsp_valid = i_locl_ack || i_locl_err_ack;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_locl_wr_strb <= 1'b0;
      o_locl_rd_strb <= 1'b0;
      pend_q         <= 1'b0;
    end else begin
      o_locl_wr_strb <= hit && ring_q.wr_strb;
      o_locl_rd_strb <= hit && ring_q.rd_strb;
      if (hit) begin
        pend_q <= 1'b1;
      end else if (rsp_valid) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      o_locl_addr    <= rel_addr[N_LOCL_ADDR_BITS-1:0];
      o_locl_wr_data <= ring_q.wr_data;
      pend_addr_q    <= ring_q.addr;
    end
  end

  // The response goes back out under the address of the request.
  always_comb begin
    rsp_word         = '0;
    rsp_word.addr    = pend_addr_q;
    rsp_word.rd_data = i_locl_rd_data;
    rsp_word.ack     = i_locl_ack;
    rsp_word.err_ack = i_locl_err_ack;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_rbus_ring <= '0;
    end else if (rsp_valid) begin
      o_rbus_ring <= rsp_word;
    end else if (hit) begin
      o_rbus_ring <= '0;
    end else begin
      o_rbus_ring <= ring_q;
    end
  end

  a_single_strobe: assert property (@(posedge clk) disable iff (i_reset)
    !(ring_q.wr_strb && ring_q.rd_strb));

  // A second request to this node before the first one is answered.
  a_one_outstanding: assert property (@(posedge clk) disable iff (i_reset)
    hit |-> !pend_q);

  // the slot taken by a local response must not hold an upstream response.
  a_no_rsp_collision: assert property (@(posedge clk) disable iff (i_reset)
    rsp_valid |-> !(ring_q.ack || ring_q.err_ack));

endmodule

`default_nettype wire

//--- source/crcgc_regs_pkg.sv
// CRC generator/checker register map, control word layout and history
// buffer entry types.
`default_nettype none

package crcgc_regs_pkg;

  // Local word addresses inside the node's window.
  localparam int REG_REVID        = 0;
  localparam int REG_SPARE        = 1;
  localparam int REG_TLV_ACTION_0 = 2;
  localparam int REG_TLV_ACTION_1 = 3;
  localparam int REG_CTRL         = 4;
  localparam int REG_HB_BASE      = 8;

  localparam int N_HB_ENTRIES = 8;
  localparam int HB_ENTRY_BITS = 96;

  // Each entry is read as three 32-bit parts, part 0 holding bits 31:0,
  // so entry n part p sits at REG_HB_BASE + 3n + p.
  localparam int N_HB_PARTS = 3;
  localparam int N_HB_WORDS = N_HB_PARTS * N_HB_ENTRIES;

  // Control word. Only the three low bits are stored.
  typedef struct packed {
    logic [28:0] reserved;
    logic        hb_freeze;
    logic        crc_chk_en;
    logic        crc_gen_en;
  } crcgc_ctrl_t;

  typedef logic [HB_ENTRY_BITS-1:0] hb_entry_t;

  typedef hb_entry_t [N_HB_ENTRIES-1:0] hb_array_t;

endpackage

`default_nettype wire

//--- source/rbus_pkg.sv
// Register ring bus widths and the ring word carried between nodes.
`default_nettype none

package rbus_pkg;

  localparam int RBUS_ADDR_BITS = 16;
  localparam int RBUS_DATA_BITS = 32;

  // One ring word. A request has exactly one strobe set, a response has
  // ack or err_ack set and carries read data back to the master.
  typedef struct packed {
    logic [RBUS_ADDR_BITS-1:0] addr;
    logic                      wr_strb;
    logic [RBUS_DATA_BITS-1:0] wr_data;
    logic                      rd_strb;
    logic [RBUS_DATA_BITS-1:0] rd_data;
    logic                      ack;
    logic                      err_ack;
  } rbus_ring_t;

endpackage

`default_nettype wire
